/* run_sim.sh */
#!/usr/bin/env bash
# Builds the string UART testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f string_uart_top.f --top-module tb_string_uart \
	&& ./obj_dir/Vtb_string_uart 2>&1 | tee sim.log

grep -q "Finished with no errors" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* string_uart_top.f */
verilog/uart_line_pkg.sv
verilog/str_frame_pkg.sv
verilog/uart_tx_serializer.sv
verilog/uart_rx_deserializer.sv
verilog/rx_frame_buffer.sv
verilog/string_frame_ctrl.sv
verilog/string_uart_top.sv
tests/tb_string_uart.sv

/* tests/tb_string_uart.sv */
/*
 * String UART testbench
 * table-driven checks of transmit framing, receive, hunting, aborted
 * frames, loopback and request ignore while busy
 */
`timescale 1ns/10ps

module tb_string_uart;

	localparam int CLK_FREQ_HZ = 1_000_000;
	localparam int BAUD_RATE   = 125_000;
	localparam int MAX_LEN     = 8;
	localparam int CPB         = CLK_FREQ_HZ / BAUD_RATE;
	localparam int LEN_W       = $clog2(MAX_LEN + 1);
	localparam int N_ROWS      = 12;
	localparam logic [7:0] MARK = "&";

	// row modes
	localparam logic [1:0] M_TX   = 2'd0;
	localparam logic [1:0] M_RX   = 2'd1;
	localparam logic [1:0] M_LOOP = 2'd2;
	localparam logic [1:0] M_BUSY = 2'd3;

	// one test with line prefix, payload, closing pair and expected receive result
	typedef struct packed {
		logic [1:0]      mode;
		logic [3:0][7:0] pre;
		logic [2:0]      pre_len;
		logic [9:0][7:0] pay;
		logic [3:0]      len;
		logic [1:0][7:0] tail;
		logic            bad_stop;
		logic            exp_done;
		logic            exp_err;
	} row_t;

	logic                   sys_clk = 1'b0;
	logic                   sys_rst_n;
	logic [MAX_LEN*8-1:0]   tx_string;
	logic [LEN_W-1:0]       tx_length;
	logic                   tx_req;
	logic                   tx_busy;
	logic                   tx_done;
	logic [MAX_LEN*8-1:0]   rx_string;
	logic [LEN_W-1:0]       rx_length;
	logic                   rx_done;
	logic                   rx_err;
	logic                   rx_line;
	logic                   tx_line;
	logic                   line_drv;
	logic                   loop_mode;

	row_t                   rows [N_ROWS];
	logic [MAX_LEN*8-1:0]   held_str = '0;
	logic [LEN_W-1:0]       held_len = '0;
	logic [MAX_LEN*8-1:0]   prev_str = '0;
	logic [LEN_W-1:0]       prev_len = '0;
	int                     tx_done_cnt = 0;
	int                     rx_done_cnt = 0;
	int                     rx_err_cnt = 0;
	int                     cycle_cnt = 0;
	int                     cycle_limit = 1000;
	integer                 seed = 32'h6d12_9e4f;

	// loopback feeds the transmit line straight back
	assign rx_line = loop_mode ? tx_line : line_drv;

	string_uart_top #(
		.CLK_FREQ_HZ (CLK_FREQ_HZ),
		.BAUD_RATE   (BAUD_RATE),
		.MAX_LEN     (MAX_LEN)
	) u_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_done      (rx_done),
		.rx_err       (rx_err),
		.uart_rx_port (rx_line),
		.uart_tx_port (tx_line)
	);

	always #5 sys_clk = ~sys_clk;

	task automatic report_fail(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1);
	endtask

	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit)
			report_fail($sformatf("Timeout: run went past %0d cycles", cycle_limit));
	end

	// count pulses and let the holding registers move only with rx_done
	always @(negedge sys_clk) begin
		if (sys_rst_n) begin
			if (tx_done)
				tx_done_cnt++;
			if (rx_done)
				rx_done_cnt++;
			if (rx_err)
				rx_err_cnt++;
			if (rx_string != prev_str || rx_length != prev_len)
				assert (rx_done) else
					report_fail("Holding registers changed without an rx_done pulse");
			prev_str = rx_string;
			prev_len = rx_length;
		end
	end

	function automatic row_t make_row(input logic [1:0] mode, input string pre_s,
			input string pay_s, input string tail_s, input logic bad,
			input logic done, input logic err);
		row_t r;
		r = '0;
		r.mode     = mode;
		r.pre_len  = 3'(pre_s.len());
		r.len      = 4'(pay_s.len());
		r.bad_stop = bad;
		r.exp_done = done;
		r.exp_err  = err;
		for (int i = 0; i < pre_s.len(); i++)
			r.pre[i] = pre_s[i];
		for (int i = 0; i < pay_s.len(); i++)
			r.pay[i] = pay_s[i];
		for (int i = 0; i < 2; i++)
			r.tail[i] = tail_s[i];
		return r;
	endfunction

	// line model sending 8N1 lsb first with a short idle gap
	task automatic send_byte(input logic [7:0] b, input logic bad);
		line_drv = 1'b0;
		repeat (CPB) @(negedge sys_clk);
		for (int i = 0; i < 8; i++) begin
			line_drv = b[i];
			repeat (CPB) @(negedge sys_clk);
		end
		line_drv = ~bad;
		repeat (CPB) @(negedge sys_clk);
		line_drv = 1'b1;
		repeat (2) @(negedge sys_clk);
	endtask

	// decode one character from uart_tx_port by mid-bit sampling
	task automatic read_tx_byte(output logic [7:0] b);
		while (tx_line !== 1'b0)
			@(negedge sys_clk);
		repeat (CPB / 2) @(negedge sys_clk);
		assert (tx_line == 1'b0) else report_fail("Start bit on uart_tx_port was too short");
		for (int i = 0; i < 8; i++) begin
			repeat (CPB) @(negedge sys_clk);
			b[i] = tx_line;
		end
		repeat (CPB) @(negedge sys_clk);
		assert (tx_line == 1'b1) else report_fail("Stop bit on uart_tx_port was low");
	endtask

	task automatic request_tx();
		tx_req = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
		assert (tx_busy == 1'b1) else
			report_fail($sformatf("Error: tx_busy expected 1, got %h", tx_busy));
	endtask

	task automatic run_tx(input row_t r, input logic second_req);
		logic [7:0] got;
		logic [7:0] want;
		int         base;
		int         n;
		base      = tx_done_cnt;
		n         = int'(r.len) + 4;
		tx_string = r.pay[MAX_LEN-1:0];
		tx_length = r.len;
		fork
			begin
				request_tx();
				if (second_req) begin
					repeat (20 * CPB) @(negedge sys_clk);
					request_tx();
				end
			end
			for (int k = 0; k < n; k++) begin
				read_tx_byte(got);
				if (k < 2 || k >= n - 2)
					want = MARK;
				else
					want = r.pay[k - 2];
				assert (got == want) else report_fail($sformatf(
					"Error: uart_tx_port byte %0d expected %h, got %h", k, want, got));
			end
		join
		while (tx_done_cnt == base)
			@(negedge sys_clk);
		repeat (2) @(negedge sys_clk);
		// an accepted second request would start a new frame here
		if (second_req) begin
			repeat (30 * CPB) begin
				@(negedge sys_clk);
				assert (tx_line == 1'b1) else
					report_fail("Ignored request still sent bytes on uart_tx_port");
			end
		end
		assert (tx_busy == 1'b0) else
			report_fail($sformatf("Error: tx_busy expected 0, got %h", tx_busy));
		assert (tx_done_cnt == base + 1) else report_fail($sformatf(
			"Error: tx_done pulse count expected %h, got %h", 1, tx_done_cnt - base));
	endtask

	task automatic check_rx(input row_t r, input int base_done, input int base_err);
		if (r.exp_done) begin
			held_len = r.len;
			held_str = r.pay[MAX_LEN-1:0];
		end
		assert (rx_done_cnt - base_done == (r.exp_done ? 1 : 0)) else report_fail(
			$sformatf("Error: rx_done pulse count expected %h, got %h",
			r.exp_done, rx_done_cnt - base_done));
		assert (rx_err_cnt - base_err == (r.exp_err ? 1 : 0)) else report_fail(
			$sformatf("Error: rx_err pulse count expected %h, got %h",
			r.exp_err, rx_err_cnt - base_err));
		assert (rx_length == held_len) else report_fail($sformatf(
			"Error: rx_length expected %h, got %h", held_len, rx_length));
		assert (rx_string == held_str) else report_fail($sformatf(
			"Error: rx_string expected %h, got %h", held_str, rx_string));
	endtask

	task automatic run_rx(input row_t r);
		int base_done;
		int base_err;
		base_done = rx_done_cnt;
		base_err  = rx_err_cnt;
		for (int i = 0; i < int'(r.pre_len); i++)
			send_byte(r.pre[i], 1'b0);
		send_byte(MARK, 1'b0);
		send_byte(MARK, 1'b0);
		for (int i = 0; i < int'(r.len); i++)
			send_byte(r.pay[i], r.bad_stop && (i == int'(r.len) - 1));
		for (int i = 0; i < 2; i++)
			send_byte(r.tail[i], 1'b0);
		if (r.exp_done) begin
			while (rx_done_cnt == base_done)
				@(negedge sys_clk);
		end else begin
			while (rx_err_cnt == base_err)
				@(negedge sys_clk);
		end
		repeat (20) @(negedge sys_clk);
		check_rx(r, base_done, base_err);
	endtask

	task automatic run_loop(input row_t r);
		row_t       lr;
		logic [7:0] rb;
		int         base_done;
		int         base_err;
		lr = r;
		// random payload bytes avoid the marker so the frame stays intact
		for (int i = 0; i < int'(r.len); i++) begin
			rb = 8'($random(seed));
			if (rb == MARK)
				rb = rb ^ 8'h01;
			lr.pay[i] = rb;
		end
		loop_mode = 1'b1;
		base_done = rx_done_cnt;
		base_err  = rx_err_cnt;
		run_tx(lr, 1'b0);
		while (rx_done_cnt == base_done)
			@(negedge sys_clk);
		repeat (20) @(negedge sys_clk);
		check_rx(lr, base_done, base_err);
		assert (rx_string == tx_string) else report_fail($sformatf(
			"Error: rx_string expected %h, got %h", tx_string, rx_string));
		loop_mode = 1'b0;
	endtask

	initial begin
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req    = 1'b0;
		line_drv  = 1'b1;
		loop_mode = 1'b0;

		rows[0]  = make_row(M_TX, "", "", "&&", 1'b0, 1'b0, 1'b0);
		rows[1]  = make_row(M_TX, "", "Z", "&&", 1'b0, 1'b0, 1'b0);
		rows[2]  = make_row(M_TX, "", "hello", "&&", 1'b0, 1'b0, 1'b0);
		rows[3]  = make_row(M_TX, "", "ABCDEFGH", "&&", 1'b0, 1'b0, 1'b0);
		rows[4]  = make_row(M_RX, "", "uart ok", "&&", 1'b0, 1'b1, 1'b0);
		rows[5]  = make_row(M_RX, "", "hi", "&&", 1'b0, 1'b1, 1'b0);
		rows[6]  = make_row(M_RX, "q7&x", "str", "&&", 1'b0, 1'b1, 1'b0);
		rows[7]  = make_row(M_RX, "", "ab", "&x", 1'b0, 1'b0, 1'b1);
		rows[8]  = make_row(M_RX, "", "123456789", "!!", 1'b0, 1'b0, 1'b1);
		rows[9]  = make_row(M_RX, "", "xyz", "!!", 1'b1, 1'b0, 1'b1);
		rows[10] = make_row(M_LOOP, "", "LOOPBK", "&&", 1'b0, 1'b1, 1'b0);
		rows[11] = make_row(M_BUSY, "", "abc", "&&", 1'b0, 1'b0, 1'b0);

		// two full frame times per row plus margin
		for (int i = 0; i < N_ROWS; i++)
			cycle_limit += 2 * (int'(rows[i].pre_len) + int'(rows[i].len) + 4) * (10 * CPB + 1);

		repeat (8) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		assert (tx_busy == 1'b0) else
			report_fail($sformatf("Error: tx_busy expected 0, got %h", tx_busy));
		assert (tx_done == 1'b0) else
			report_fail($sformatf("Error: tx_done expected 0, got %h", tx_done));
		assert (rx_done == 1'b0) else
			report_fail($sformatf("Error: rx_done expected 0, got %h", rx_done));
		assert (rx_err == 1'b0) else
			report_fail($sformatf("Error: rx_err expected 0, got %h", rx_err));
		assert (tx_line == 1'b1) else
			report_fail($sformatf("Error: uart_tx_port expected 1, got %h", tx_line));
		assert (rx_string == '0) else
			report_fail($sformatf("Error: rx_string expected 0, got %h", rx_string));
		assert (rx_length == '0) else
			report_fail($sformatf("Error: rx_length expected 0, got %h", rx_length));

		for (int r = 0; r < N_ROWS; r++) begin
			case (rows[r].mode)
				M_TX:    run_tx(rows[r], 1'b0);
				M_BUSY:  run_tx(rows[r], 1'b1);
				M_RX:    run_rx(rows[r]);
				default: run_loop(rows[r]);
			endcase
		end

		$display("Finished with no errors");
		$finish;
	end

endmodule

/* verilog/rx_frame_buffer.sv */
/*
 * Receive frame buffer
 * collects payload bytes in a working register and copies them with
 * their count into the holding registers on commit
 */
`timescale 1ns/10ps

module rx_frame_buffer #(
	parameter int MAX_LEN = 16
) (
	input  logic                          sys_clk,
	input  logic                          sys_rst_n,
	input  str_frame_pkg::rx_buf_cmd_t    buf_cmd,
	output logic                          buf_full,
	output logic [MAX_LEN*8-1:0]          rx_string,
	output logic [$clog2(MAX_LEN + 1)-1:0] rx_length
);

	localparam int LEN_W = $clog2(MAX_LEN + 1);

	logic [MAX_LEN-1:0][7:0] work;
	logic [LEN_W-1:0]        wr_idx;

	assign buf_full = (wr_idx == LEN_W'(MAX_LEN));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			wr_idx <= '0;
		else if (buf_cmd.clear)
			wr_idx <= '0;
		else if (buf_cmd.write)
			wr_idx <= wr_idx + 1'b1;
	end

	always_ff @(posedge sys_clk) begin
		if (buf_cmd.write) begin
			for (int i = 0; i < MAX_LEN; i++) begin
				if (wr_idx == LEN_W'(i))
					work[i] <= buf_cmd.data;
			end
		end
	end

	// bytes past the write index may be left over from an older frame
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_string <= '0;
			rx_length <= '0;
		end else if (buf_cmd.commit) begin
			rx_length <= wr_idx;
			for (int i = 0; i < MAX_LEN; i++)
				rx_string[8*i +: 8] <= (LEN_W'(i) < wr_idx) ? work[i] : 8'h00;
		end
	end

	a_no_write_full: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(buf_cmd.write && buf_full));

endmodule

/* verilog/str_frame_pkg.sv */
/*
 * String framing definitions
 * marker character, transmit and receive FSM encodings and the
 * command word sent to the receive buffer
 */
package str_frame_pkg;

	// "&" opens and closes every frame, two of each
	localparam logic [7:0] MARKER = 8'h26;

	// one-hot transmit states
	typedef enum logic [6:0] {
		TX_IDLE    = 7'b000_0001,
		TX_MARK1   = 7'b000_0010,
		TX_MARK2   = 7'b000_0100,
		TX_PAYLOAD = 7'b000_1000,
		TX_MARK3   = 7'b001_0000,
		TX_MARK4   = 7'b010_0000,
		TX_FINISH  = 7'b100_0000
	} tx_state_t;

	typedef enum logic [2:0] {
		RX_HUNT,
		RX_MARK1_SEEN,
		RX_PAYLOAD,
		RX_MARK3_SEEN,
		RX_COMMIT
	} rx_state_t;

	// all three flags are single-cycle strobes
	typedef struct packed {
		logic       clear;
		logic       write;
		logic       commit;
		logic [7:0] data;
	} rx_buf_cmd_t;

endpackage

/* verilog/string_frame_ctrl.sv */
/*
 * String frame control
 * transmit FSM that sequences markers and payload into the serializer,
 * receive FSM that hunts for "&&", fills the buffer and checks the close
 */
`timescale 1ns/10ps

module string_frame_ctrl #(
	parameter int MAX_LEN = 16
) (
	input  logic                           sys_clk,
	input  logic                           sys_rst_n,
	input  logic [MAX_LEN*8-1:0]           tx_string,
	input  logic [$clog2(MAX_LEN + 1)-1:0] tx_length,
	input  logic                           tx_req,
	output logic                           tx_busy,
	output logic                           tx_done,
	output logic                           byte_start,
	output logic [7:0]                     byte_data,
	input  logic                           byte_done,
	input  uart_line_pkg::ser_byte_t       rx_byte,
	input  logic                           line_err,
	output str_frame_pkg::rx_buf_cmd_t     buf_cmd,
	input  logic                           buf_full,
	output logic                           rx_done,
	output logic                           rx_err
);

	localparam int LEN_W = $clog2(MAX_LEN + 1);

	str_frame_pkg::tx_state_t tx_state;
	str_frame_pkg::tx_state_t tx_next;
	str_frame_pkg::rx_state_t rx_state;
	str_frame_pkg::rx_state_t rx_next;
	logic [LEN_W-1:0]         tx_idx;
	logic [7:0]               tx_pick;
	logic                     tx_launch;
	logic                     tx_use_payload;
	logic                     rx_abort;
	logic                     rx_is_marker;
	logic                     in_flight;

	assign tx_busy = (tx_state != str_frame_pkg::TX_IDLE);
	assign tx_done = (tx_state == str_frame_pkg::TX_FINISH);
	assign rx_done = (rx_state == str_frame_pkg::RX_COMMIT);
	assign rx_is_marker = (rx_byte.data == str_frame_pkg::MARKER);

	// payload byte at the current index
	always_comb begin
		tx_pick = '0;
		for (int i = 0; i < MAX_LEN; i++) begin
			if (tx_idx == LEN_W'(i))
				tx_pick = tx_string[8*i +: 8];
		end
	end

	// next byte is launched in the cycle after byte_done
	always_comb begin
		tx_next        = tx_state;
		tx_launch      = 1'b0;
		tx_use_payload = 1'b0;
		case (tx_state)
			str_frame_pkg::TX_IDLE: begin
				if (tx_req) begin
					tx_next   = str_frame_pkg::TX_MARK1;
					tx_launch = 1'b1;
				end
			end
			str_frame_pkg::TX_MARK1: begin
				if (byte_done) begin
					tx_next   = str_frame_pkg::TX_MARK2;
					tx_launch = 1'b1;
				end
			end
			str_frame_pkg::TX_MARK2: begin
				if (byte_done) begin
					tx_launch = 1'b1;
					if (tx_length == '0) begin
						tx_next = str_frame_pkg::TX_MARK3;
					end else begin
						tx_next        = str_frame_pkg::TX_PAYLOAD;
						tx_use_payload = 1'b1;
					end
				end
			end
			str_frame_pkg::TX_PAYLOAD: begin
				if (byte_done) begin
					tx_launch = 1'b1;
					if (tx_idx == tx_length)
						tx_next = str_frame_pkg::TX_MARK3;
					else
						tx_use_payload = 1'b1;
				end
			end
			str_frame_pkg::TX_MARK3: begin
				if (byte_done) begin
					tx_next   = str_frame_pkg::TX_MARK4;
					tx_launch = 1'b1;
				end
			end
			str_frame_pkg::TX_MARK4: begin
				if (byte_done)
					tx_next = str_frame_pkg::TX_FINISH;
			end
			default: tx_next = str_frame_pkg::TX_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state   <= str_frame_pkg::TX_IDLE;
			byte_start <= 1'b0;
			tx_idx     <= '0;
		end else begin
			tx_state   <= tx_next;
			byte_start <= tx_launch;
			if (tx_state == str_frame_pkg::TX_IDLE)
				tx_idx <= '0;
			else if (tx_use_payload)
				tx_idx <= tx_idx + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (tx_launch)
			byte_data <= tx_use_payload ? tx_pick : str_frame_pkg::MARKER;
	end

	// a character is in flight from byte_start until byte_done
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			in_flight <= 1'b0;
		else if (byte_start)
			in_flight <= 1'b1;
		else if (byte_done)
			in_flight <= 1'b0;
	end

	// buffer commands go out in the same cycle as the received byte
	always_comb begin
		rx_next      = rx_state;
		rx_abort     = 1'b0;
		buf_cmd      = '0;
		buf_cmd.data = rx_byte.data;
		case (rx_state)
			str_frame_pkg::RX_HUNT: begin
				if (rx_byte.valid && rx_is_marker)
					rx_next = str_frame_pkg::RX_MARK1_SEEN;
			end
			str_frame_pkg::RX_MARK1_SEEN: begin
				if (rx_byte.valid) begin
					if (rx_is_marker) begin
						rx_next       = str_frame_pkg::RX_PAYLOAD;
						buf_cmd.clear = 1'b1;
					end else begin
						rx_next = str_frame_pkg::RX_HUNT;
					end
				end
			end
			str_frame_pkg::RX_PAYLOAD: begin
				if (rx_byte.valid) begin
					if (rx_is_marker)
						rx_next = str_frame_pkg::RX_MARK3_SEEN;
					else if (buf_full)
						rx_abort = 1'b1;
					else
						buf_cmd.write = 1'b1;
				end
			end
			str_frame_pkg::RX_MARK3_SEEN: begin
				if (rx_byte.valid) begin
					if (rx_is_marker) begin
						rx_next        = str_frame_pkg::RX_COMMIT;
						buf_cmd.commit = 1'b1;
					end else begin
						rx_abort = 1'b1;
					end
				end
			end
			default: rx_next = str_frame_pkg::RX_HUNT;
		endcase
		// bad stop bit anywhere inside a frame
		if (line_err && rx_state != str_frame_pkg::RX_HUNT &&
		    rx_state != str_frame_pkg::RX_COMMIT)
			rx_abort = 1'b1;
		if (rx_abort) begin
			rx_next        = str_frame_pkg::RX_HUNT;
			buf_cmd.clear  = 1'b1;
			buf_cmd.write  = 1'b0;
			buf_cmd.commit = 1'b0;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state <= str_frame_pkg::RX_HUNT;
			rx_err   <= 1'b0;
		end else begin
			rx_state <= rx_next;
			rx_err   <= rx_abort;
		end
	end

	a_start_free: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_start |-> !in_flight);

	a_done_xor_err: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(rx_done && rx_err));

endmodule

/* verilog/string_uart_top.sv */
/*
 * String UART top level
 * sends and receives "&&payload&&" frames over one 8N1 line
 */
`timescale 1ns/10ps

module string_uart_top #(
	parameter int CLK_FREQ_HZ = 50_000_000,
	parameter int BAUD_RATE   = 115_200,
	parameter int MAX_LEN     = 16
) (
	input  logic                           sys_clk,
	input  logic                           sys_rst_n,
	input  logic [MAX_LEN*8-1:0]           tx_string,
	input  logic [$clog2(MAX_LEN + 1)-1:0] tx_length,
	input  logic                           tx_req,
	output logic                           tx_busy,
	output logic                           tx_done,
	output logic [MAX_LEN*8-1:0]           rx_string,
	output logic [$clog2(MAX_LEN + 1)-1:0] rx_length,
	output logic                           rx_done,
	output logic                           rx_err,
	input  logic                           uart_rx_port,
	output logic                           uart_tx_port
);

	// integer divide, baud error grows at low clock ratios
	localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;

	logic                       byte_start;
	logic [7:0]                 byte_data;
	logic                       byte_done;
	uart_line_pkg::ser_byte_t   rx_byte;
	logic                       line_err;
	str_frame_pkg::rx_buf_cmd_t buf_cmd;
	logic                       buf_full;

	string_frame_ctrl #(
		.MAX_LEN (MAX_LEN)
	) u_ctrl (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.tx_string  (tx_string),
		.tx_length  (tx_length),
		.tx_req     (tx_req),
		.tx_busy    (tx_busy),
		.tx_done    (tx_done),
		.byte_start (byte_start),
		.byte_data  (byte_data),
		.byte_done  (byte_done),
		.rx_byte    (rx_byte),
		.line_err   (line_err),
		.buf_cmd    (buf_cmd),
		.buf_full   (buf_full),
		.rx_done    (rx_done),
		.rx_err     (rx_err)
	);

	uart_tx_serializer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_tx (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.byte_start (byte_start),
		.byte_data  (byte_data),
		.byte_done  (byte_done),
		.tx_line    (uart_tx_port)
	);

	uart_rx_deserializer #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_line   (uart_rx_port),
		.rx_byte   (rx_byte),
		.line_err  (line_err)
	);

	rx_frame_buffer #(
		.MAX_LEN (MAX_LEN)
	) u_buf (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.buf_cmd   (buf_cmd),
		.buf_full  (buf_full),
		.rx_string (rx_string),
		.rx_length (rx_length)
	);

endmodule

/* verilog/uart_line_pkg.sv */
/*
 * UART line format
 * character layout of the 8N1 serial line, its idle level and the
 * struct that carries a received character to the framing logic
 */
package uart_line_pkg;

	// data bits per character, sent lsb first
	localparam int DATA_BITS = 8;

	// start + data + one stop bit
	localparam int FRAME_BITS = DATA_BITS + 2;

	// mark level, also the stop bit value
	localparam logic LINE_IDLE = 1'b1;

	// one received character, valid is a single-cycle strobe
	typedef struct packed {
		logic                 valid;
		logic [DATA_BITS-1:0] data;
	} ser_byte_t;

endpackage

/* verilog/uart_rx_deserializer.sv */
/*
 * UART receive deserializer
 * synchronizes the line, confirms a start bit at half a bit time and
 * samples each following bit in its middle
 */
`timescale 1ns/10ps

module uart_rx_deserializer #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic                     sys_clk,
	input  logic                     sys_rst_n,
	input  logic                     rx_line,
	output uart_line_pkg::ser_byte_t rx_byte,
	output logic                     line_err
);

	localparam int DB    = uart_line_pkg::DATA_BITS;
	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam int IDX_W = $clog2(DB);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [IDX_W-1:0] IDX_LAST  = IDX_W'(DB - 1);

	typedef enum logic [1:0] {
		RXD_IDLE,
		RXD_START,
		RXD_DATA,
		RXD_STOP
	} rxd_state_t;

	rxd_state_t       state;
	logic [1:0]       sync_ff;
	logic             rx_sync;
	logic             line_prev;
	logic [CNT_W-1:0] cnt;
	logic [IDX_W-1:0] bit_idx;
	logic [DB-1:0]    shift;
	logic             byte_vld;

	assign rx_sync = sync_ff[1];
	assign rx_byte.valid = byte_vld;
	assign rx_byte.data  = shift;

	// two-flop synchronizer plus one delayed copy for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sync_ff   <= {2{uart_line_pkg::LINE_IDLE}};
			line_prev <= uart_line_pkg::LINE_IDLE;
		end else begin
			sync_ff   <= {sync_ff[0], rx_line};
			line_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= RXD_IDLE;
			cnt      <= '0;
			bit_idx  <= '0;
			byte_vld <= 1'b0;
			line_err <= 1'b0;
		end else begin
			byte_vld <= 1'b0;
			line_err <= 1'b0;
			cnt      <= cnt + 1'b1;
			case (state)
				RXD_IDLE: begin
					cnt <= '0;
					// falling edge only, a stuck-low line does not retrigger
					if (line_prev == uart_line_pkg::LINE_IDLE &&
					    rx_sync != uart_line_pkg::LINE_IDLE)
						state <= RXD_START;
				end
				RXD_START: begin
					if (cnt == HALF_LAST) begin
						cnt     <= '0;
						bit_idx <= '0;
						// line back high by now means a glitch
						state   <= (rx_sync == uart_line_pkg::LINE_IDLE) ? RXD_IDLE : RXD_DATA;
					end
				end
				RXD_DATA: begin
					if (cnt == BIT_LAST) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == IDX_LAST)
							state <= RXD_STOP;
					end
				end
				RXD_STOP: begin
					if (cnt == BIT_LAST) begin
						state <= RXD_IDLE;
						if (rx_sync == uart_line_pkg::LINE_IDLE)
							byte_vld <= 1'b1;
						else
							line_err <= 1'b1;
					end
				end
				default: state <= RXD_IDLE;
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge sys_clk) begin
		if (state == RXD_DATA && cnt == BIT_LAST)
			shift <= {rx_sync, shift[DB-1:1]};
	end

endmodule

/* verilog/uart_tx_serializer.sv */
/*
 * UART transmit serializer
 * sends one byte as start, 8 data bits lsb first and one stop bit,
 * then pulses byte_done in the last cycle of the stop bit
 */
`timescale 1ns/10ps

module uart_tx_serializer #(
	parameter int CLKS_PER_BIT = 8
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       byte_start,
	input  logic [7:0] byte_data,
	output logic       byte_done,
	output logic       tx_line
);

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam int BIT_W = $clog2(uart_line_pkg::FRAME_BITS);
	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [BIT_W-1:0] DATA_LAST = BIT_W'(uart_line_pkg::DATA_BITS);
	localparam logic [BIT_W-1:0] STOP_IDX  = BIT_W'(uart_line_pkg::FRAME_BITS - 1);

	logic                                busy;
	logic [CNT_W-1:0]                    baud_cnt;
	logic [BIT_W-1:0]                    bit_cnt;
	logic [uart_line_pkg::DATA_BITS-1:0] shift;

	assign byte_done = busy && (bit_cnt == STOP_IDX) && (baud_cnt == BIT_LAST);

	// bit_cnt 0 is the start bit, 1..8 data, 9 stop
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			tx_line  <= uart_line_pkg::LINE_IDLE;
		end else if (!busy) begin
			if (byte_start) begin
				busy     <= 1'b1;
				baud_cnt <= '0;
				bit_cnt  <= '0;
				tx_line  <= ~uart_line_pkg::LINE_IDLE;
			end
		end else if (baud_cnt == BIT_LAST) begin
			baud_cnt <= '0;
			bit_cnt  <= bit_cnt + 1'b1;
			if (bit_cnt == STOP_IDX)
				busy <= 1'b0;
			else if (bit_cnt == DATA_LAST)
				tx_line <= uart_line_pkg::LINE_IDLE;
			else
				tx_line <= shift[0];
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!busy && byte_start)
			shift <= byte_data;
		else if (busy && (baud_cnt == BIT_LAST) && (bit_cnt < DATA_LAST))
			shift <= shift >> 1;
	end

	a_idle_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!busy |-> (tx_line == uart_line_pkg::LINE_IDLE));

endmodule
